// File: hdl/nes_bridge_pkg.sv
// shared types for the NES board bridge
// address, button, register-write and memory command structs
// memory opcode enum and host register addresses
package nes_bridge_pkg;

  // 4 MB ROM and RAM space
  typedef logic [21:0] rom_addr_t;

  // NES controller order, MSB first
  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
    logic start;
    logic select;
    logic b;
    logic a;
  } nes_buttons_t;

  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] data;
    logic       valid;
  } host_wr_t;

  typedef struct packed {
    rom_addr_t  addr;
    logic [7:0] data;
    logic       valid;
  } loader_wr_t;

  typedef enum logic [2:0] {
    MEM_IDLE,
    MEM_READ_CPU,
    MEM_READ_PPU,
    MEM_WRITE,
    MEM_REFRESH
  } mem_op_e;

  // access request from the NES core
  typedef struct packed {
    logic       read_cpu;
    logic       read_ppu;
    logic       write;
    rom_addr_t  addr;
    logic [7:0] data;
  } nes_mem_req_t;

  typedef struct packed {
    mem_op_e    op;
    rom_addr_t  addr;
    logic [7:0] data;
  } mem_cmd_t;

  // one clock bit per player
  typedef struct packed {
    logic       strobe;
    logic [1:0] clk;
  } pad_ctrl_t;

  // host register map
  localparam logic [7:0] REG_LOADER_CONF = 8'h35;
  localparam logic [7:0] REG_BTN_P1      = 8'h40;
  localparam logic [7:0] REG_BTN_P2      = 8'h41;

endpackage

// File: hdl/reset_sequencer.sv
// core reset generation
// power-on countdown, then reset button and Select+Down combo
`timescale 1ns/1ps

module reset_sequencer #(
  parameter int RESET_CYCLES = 255
) (
  input  logic                        clk,
  input  logic                        sys_resetn,
  input  logic                        i_reset_btn,
  input  nes_bridge_pkg::nes_buttons_t i_buttons_p1,
  output logic                        o_core_resetn
);

  logic [7:0] cnt_q;
  logic       combo;

  // home button on some pads sends Select+Down
  assign combo = i_buttons_p1.select & i_buttons_p1.down;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      cnt_q         <= 8'(RESET_CYCLES);
      o_core_resetn <= 1'b0;
    end else begin
      if (cnt_q != 8'd0) begin
        cnt_q         <= cnt_q - 8'd1;
        o_core_resetn <= 1'b0;
      end else begin
        // countdown finished, follow the buttons
        o_core_resetn <= ~i_reset_btn & ~combo;
      end
    end
  end

endmodule

// File: hdl/host_regs.sv
// host register block
// loader configuration and forced button bytes for both players
`timescale 1ns/1ps

module host_regs (
  input  logic                         clk,
  input  logic                         sys_resetn,
  input  nes_bridge_pkg::host_wr_t     i_host_wr,
  output logic                         o_loader_reset,
  output nes_bridge_pkg::nes_buttons_t o_btn_p1,
  output nes_bridge_pkg::nes_buttons_t o_btn_p2
);

  import nes_bridge_pkg::*;

  // bit 0 of the configuration byte, the only bit with a meaning here
  logic conf_reset_q;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      conf_reset_q <= 1'b0;
      o_btn_p1     <= '0;
      o_btn_p2     <= '0;
    end else if (i_host_wr.valid) begin
      case (i_host_wr.addr)
        REG_LOADER_CONF: begin
          conf_reset_q <= i_host_wr.data[0];
        end
        REG_BTN_P1: begin
          o_btn_p1 <= nes_buttons_t'(i_host_wr.data);
        end
        REG_BTN_P2: begin
          o_btn_p2 <= nes_buttons_t'(i_host_wr.data);
        end
        default: begin
          // other addresses are ignored
        end
      endcase
    end
  end

  // loader held while the board is in reset or the host asks for it
  assign o_loader_reset = ~sys_resetn | conf_reset_q;

endmodule

// File: hdl/rom_patch.sv
// ROM patch table
// replaces loader bytes at fixed ROM addresses
`timescale 1ns/1ps

module rom_patch (
  input  nes_bridge_pkg::rom_addr_t i_addr,
  input  logic [7:0]                i_data,
  output logic [7:0]                o_data
);

  import nes_bridge_pkg::*;

  localparam int N_PATCH = 8;

  // addresses are raw ROM offsets, iNES header already stripped
  localparam rom_addr_t PATCH_ADDR [N_PATCH] = '{
    22'h000755,
    22'h000756,
    22'h000757,
    22'h00075D,
    22'h000764,
    22'h003443,
    22'h0061D2,
    22'h0061E2
  };

  localparam logic [7:0] PATCH_DATA [N_PATCH] = '{
    // HUD text tiles
    8'h0A,
    8'h1B,
    8'h18,
    8'h0C,
    8'h28,
    // max run speed to the right
    8'h70,
    // fireball movement
    8'hCF,
    8'hCF
  };

  always_comb begin
    o_data = i_data;
    for (int i = 0; i < N_PATCH; i++) begin
      if (i_addr == PATCH_ADDR[i]) begin
        o_data = PATCH_DATA[i];
      end
    end
  end

endmodule

// File: hdl/phase_sequencer.sv
// NES clock-enable sequencer
// phase counter with one memory slot and one NES step per period
`timescale 1ns/1ps

module phase_sequencer #(
  parameter int NES_PHASES = 5
) (
  input  logic clk,
  input  logic sys_resetn,
  input  logic i_enable,
  input  logic i_slot_free,
  output logic o_run_mem,
  output logic o_run_nes
);

  localparam int PW = $clog2(NES_PHASES);
  localparam logic [PW-1:0] LAST = PW'(NES_PHASES - 1);

  logic [PW-1:0] phase_q;

  always_ff @(posedge clk) begin
    if (!sys_resetn || !i_enable) begin
      phase_q <= '0;
    end else if (phase_q == '0 && !i_slot_free) begin
      // wait at phase 0 until the command slot drains
      phase_q <= '0;
    end else if (phase_q == LAST) begin
      phase_q <= '0;
    end else begin
      phase_q <= phase_q + 1'b1;
    end
  end

  assign o_run_mem = i_enable & (phase_q == '0) & i_slot_free;
  assign o_run_nes = i_enable & (phase_q == LAST);

endmodule

// File: hdl/mem_arbiter.sv
// memory command arbiter
// one-entry command slot fed by loader writes and NES slots
// loader handshake and opcode selection
`timescale 1ns/1ps

module mem_arbiter (
  input  logic                         clk,
  input  logic                         sys_resetn,
  input  nes_bridge_pkg::loader_wr_t   i_loader_wr,
  input  logic [7:0]                   i_patched_data,
  input  logic                         i_loader_done,
  input  logic                         i_run_mem,
  input  nes_bridge_pkg::nes_mem_req_t i_nes_req,
  input  logic                         i_mem_ready,
  output logic                         o_loader_ready,
  output logic                         o_slot_free,
  output nes_bridge_pkg::mem_cmd_t     o_mem_cmd,
  output logic                         o_mem_valid
);

  import nes_bridge_pkg::*;

  logic     free_q;
  logic     loader_acc;
  logic     fill;
  logic     valid_d;
  mem_cmd_t cmd_d;

  assign o_slot_free    = free_q;
  assign o_loader_ready = free_q & ~i_loader_done;
  assign loader_acc     = i_loader_wr.valid & o_loader_ready;
  assign fill           = loader_acc | i_run_mem;

  // slot stays full until the controller takes the command
  assign valid_d = fill | (o_mem_valid & ~i_mem_ready);

  always_comb begin
    cmd_d.addr = i_nes_req.addr;
    cmd_d.data = i_nes_req.data;
    if (loader_acc) begin
      cmd_d.op   = MEM_WRITE;
      cmd_d.addr = i_loader_wr.addr;
      cmd_d.data = i_patched_data;
    end else if (i_run_mem) begin
      // write wins over reads, idle slots refresh
      if (i_nes_req.write) cmd_d.op = MEM_WRITE;
      else if (i_nes_req.read_cpu) cmd_d.op = MEM_READ_CPU;
      else if (i_nes_req.read_ppu) cmd_d.op = MEM_READ_PPU;
      else cmd_d.op = MEM_REFRESH;
    end else begin
      cmd_d.op = MEM_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      o_mem_valid <= 1'b0;
      free_q      <= 1'b0;
    end else begin
      o_mem_valid <= valid_d;
      free_q      <= ~valid_d;
    end
  end

  // payload only changes when the slot is filled
  always_ff @(posedge clk) begin
    if (fill) begin
      o_mem_cmd <= cmd_d;
    end
  end

endmodule

// File: hdl/joypad_port.sv
// joypad port for one player
// strobe latch and serial shift register toward the NES core
`timescale 1ns/1ps

module joypad_port (
  input  logic                         clk,
  input  logic                         sys_resetn,
  input  logic                         i_strobe,
  input  logic                         i_pad_clk,
  input  nes_bridge_pkg::nes_buttons_t i_buttons,
  output logic                         o_serial
);

  logic [7:0] shift_q;
  logic       pad_clk_q;
  logic       pad_fall;

  // previous clock level high, current low
  assign pad_fall = pad_clk_q & ~i_pad_clk;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      shift_q   <= '0;
      pad_clk_q <= 1'b0;
    end else begin
      pad_clk_q <= i_pad_clk;
      if (pad_fall) begin
        // zeros shift in once all eight buttons are out
        shift_q <= {1'b0, shift_q[7:1]};
      end else if (i_strobe) begin
        shift_q <= i_buttons;
      end
    end
  end

  assign o_serial = shift_q[0];

endmodule

// File: hdl/nes_bridge_top.sv
// NES board bridge top level
// reset, host registers, ROM patching, phase sequencing,
// memory arbitration and both joypad ports
`timescale 1ns/1ps

module nes_bridge_top #(
  parameter int RESET_CYCLES = 255,
  parameter int NES_PHASES   = 5
) (
  input  logic                         clk,
  input  logic                         sys_resetn,
  input  logic                         i_reset_btn,
  input  nes_bridge_pkg::host_wr_t     i_host_wr,
  input  nes_bridge_pkg::loader_wr_t   i_loader_wr,
  output logic                         o_loader_ready,
  input  logic                         i_loader_done,
  input  nes_bridge_pkg::nes_mem_req_t i_nes_req,
  output nes_bridge_pkg::mem_cmd_t     o_mem_cmd,
  output logic                         o_mem_valid,
  input  logic                         i_mem_ready,
  input  nes_bridge_pkg::pad_ctrl_t    i_pad_ctrl,
  input  nes_bridge_pkg::nes_buttons_t i_pad_btn_p1,
  input  nes_bridge_pkg::nes_buttons_t i_pad_btn_p2,
  output logic [1:0]                   o_pad_data,
  output logic                         o_run_nes,
  output logic                         o_core_resetn,
  output logic                         o_loader_reset
);

  import nes_bridge_pkg::*;

  nes_buttons_t forced_p1;
  nes_buttons_t forced_p2;
  nes_buttons_t btn_p1;
  nes_buttons_t btn_p2;
  logic [7:0]   patched_data;
  logic         run_mem;
  logic         slot_free;

  // gamepad buttons plus whatever the host forces
  assign btn_p1 = i_pad_btn_p1 | forced_p1;
  assign btn_p2 = i_pad_btn_p2 | forced_p2;

  reset_sequencer #(
    .RESET_CYCLES(RESET_CYCLES)
  ) reset_sequencer_i (
    .clk          (clk),
    .sys_resetn   (sys_resetn),
    .i_reset_btn  (i_reset_btn),
    .i_buttons_p1 (btn_p1),
    .o_core_resetn(o_core_resetn)
  );

  host_regs host_regs_i (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .i_host_wr     (i_host_wr),
    .o_loader_reset(o_loader_reset),
    .o_btn_p1      (forced_p1),
    .o_btn_p2      (forced_p2)
  );

  rom_patch rom_patch_i (
    .i_addr(i_loader_wr.addr),
    .i_data(i_loader_wr.data),
    .o_data(patched_data)
  );

  // NES runs only once the core is out of reset and the ROM is loaded
  phase_sequencer #(
    .NES_PHASES(NES_PHASES)
  ) phase_sequencer_i (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .i_enable   (o_core_resetn & i_loader_done),
    .i_slot_free(slot_free),
    .o_run_mem  (run_mem),
    .o_run_nes  (o_run_nes)
  );

  mem_arbiter mem_arbiter_i (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .i_loader_wr   (i_loader_wr),
    .i_patched_data(patched_data),
    .i_loader_done (i_loader_done),
    .i_run_mem     (run_mem),
    .i_nes_req     (i_nes_req),
    .i_mem_ready   (i_mem_ready),
    .o_loader_ready(o_loader_ready),
    .o_slot_free   (slot_free),
    .o_mem_cmd     (o_mem_cmd),
    .o_mem_valid   (o_mem_valid)
  );

  joypad_port joypad_port_p1_i (
    .clk       (clk),
    .sys_resetn(sys_resetn),
    .i_strobe  (i_pad_ctrl.strobe),
    .i_pad_clk (i_pad_ctrl.clk[0]),
    .i_buttons (btn_p1),
    .o_serial  (o_pad_data[0])
  );

  joypad_port joypad_port_p2_i (
    .clk       (clk),
    .sys_resetn(sys_resetn),
    .i_strobe  (i_pad_ctrl.strobe),
    .i_pad_clk (i_pad_ctrl.clk[1]),
    .i_buttons (btn_p2),
    .o_serial  (o_pad_data[1])
  );

endmodule

// File: bench/nes_bridge_properties.sv
// concurrent assertions for the NES board bridge
// memory command hold, loader port closing, phase separation
`timescale 1ns/1ps

module nes_bridge_properties (
  input logic                     clk,
  input logic                     sys_resetn,
  input nes_bridge_pkg::mem_cmd_t i_mem_cmd,
  input logic                     i_mem_valid,
  input logic                     i_mem_ready,
  input logic                     i_loader_valid,
  input logic                     i_loader_ready,
  input logic                     i_loader_done,
  input logic                     i_run_mem,
  input logic                     i_run_nes
);

  // count of failed assertions
  int n_fail = 0;

  // command waits unchanged until the controller takes it
  cmd_held: assert property (@(posedge clk) disable iff (!sys_resetn)
    i_mem_valid && !i_mem_ready |=> i_mem_valid && $stable(i_mem_cmd))
    else begin
      $error("memory command changed or dropped while waiting for ready");
      n_fail++;
    end

  loader_closed: assert property (@(posedge clk) disable iff (!sys_resetn)
    i_loader_done |-> !(i_loader_valid && i_loader_ready))
    else begin
      $error("loader write accepted after loading was done");
      n_fail++;
    end

  // memory slot and NES step sit in different phases
  phases_apart: assert property (@(posedge clk) disable iff (!sys_resetn)
    !(i_run_mem && i_run_nes))
    else begin
      $error("run_mem and run_nes high in the same cycle");
      n_fail++;
    end

endmodule

bind nes_bridge_top nes_bridge_properties nes_bridge_properties_i (
  .clk           (clk),
  .sys_resetn    (sys_resetn),
  .i_mem_cmd     (o_mem_cmd),
  .i_mem_valid   (o_mem_valid),
  .i_mem_ready   (i_mem_ready),
  .i_loader_valid(i_loader_wr.valid),
  .i_loader_ready(o_loader_ready),
  .i_loader_done (i_loader_done),
  .i_run_mem     (run_mem),
  .i_run_nes     (o_run_nes)
);

// File: bench/tb_nes_bridge.sv
// testbench for the NES board bridge
// reset, host registers, patched loader writes, NES phases, joypads
// random stimulus checked against a reference model, with a watchdog
`timescale 1ns/1ps

module tb_nes_bridge;

  import nes_bridge_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int NES_PHASES   = 5;
  localparam logic [31:0] SEED = 32'h08f8cb4b;
  localparam int N_HOST   = 12;
  localparam int N_LOAD   = 40;
  localparam int N_RUN    = 30;
  localparam int N_PAD    = 60;
  localparam int N_DIRECT = 40;
  localparam int TOTAL_TX = N_HOST + N_LOAD + N_RUN + N_PAD + N_DIRECT;
  localparam int LIMIT    = RESET_CYCLES + 4 + TOTAL_TX * 4 * NES_PHASES;

  // reference patch table
  localparam rom_addr_t TBL_ADDR [8] = '{22'h000755, 22'h000756, 22'h000757, 22'h00075D,
                                         22'h000764, 22'h003443, 22'h0061D2, 22'h0061E2};
  localparam logic [7:0] TBL_DATA [8] = '{8'h0A, 8'h1B, 8'h18, 8'h0C,
                                          8'h28, 8'h70, 8'hCF, 8'hCF};

  logic         clk;
  logic         sys_resetn;
  logic         i_reset_btn;
  host_wr_t     i_host_wr;
  loader_wr_t   i_loader_wr;
  logic         o_loader_ready;
  logic         i_loader_done;
  nes_mem_req_t i_nes_req;
  mem_cmd_t     o_mem_cmd;
  logic         o_mem_valid;
  logic         i_mem_ready;
  pad_ctrl_t    i_pad_ctrl;
  nes_buttons_t i_pad_btn_p1;
  nes_buttons_t i_pad_btn_p2;
  logic [1:0]   o_pad_data;
  logic         o_run_nes;
  logic         o_core_resetn;
  logic         o_loader_reset;

  // model state
  logic [31:0]  rng_state = SEED;
  logic [31:0]  ready_state = ~SEED;
  mem_cmd_t     exp_q [$];
  int           n_xfer = 0;
  logic [7:0]   host_p1 = '0;
  logic [7:0]   host_p2 = '0;
  logic [7:0]   pad_model [2] = '{8'h00, 8'h00};
  logic [1:0]   pad_clk_prev = '0;

  nes_bridge_top #(
    .RESET_CYCLES(RESET_CYCLES),
    .NES_PHASES  (NES_PHASES)
  ) nes_bridge_top_i (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .i_reset_btn   (i_reset_btn),
    .i_host_wr     (i_host_wr),
    .i_loader_wr   (i_loader_wr),
    .o_loader_ready(o_loader_ready),
    .i_loader_done (i_loader_done),
    .i_nes_req     (i_nes_req),
    .o_mem_cmd     (o_mem_cmd),
    .o_mem_valid   (o_mem_valid),
    .i_mem_ready   (i_mem_ready),
    .i_pad_ctrl    (i_pad_ctrl),
    .i_pad_btn_p1  (i_pad_btn_p1),
    .i_pad_btn_p2  (i_pad_btn_p2),
    .o_pad_data    (o_pad_data),
    .o_run_nes     (o_run_nes),
    .o_core_resetn (o_core_resetn),
    .o_loader_reset(o_loader_reset)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  function automatic logic [7:0] patch_byte(input rom_addr_t a, input logic [7:0] d);
    logic [7:0] r;
    r = d;
    for (int i = 0; i < 8; i++) begin
      if (a == TBL_ADDR[i]) begin
        r = TBL_DATA[i];
      end
    end
    return r;
  endfunction

  // write first, then CPU read, then PPU read, idle refreshes
  function automatic mem_op_e expected_op(input nes_mem_req_t q);
    if (q.write) begin
      return MEM_WRITE;
    end else if (q.read_cpu) begin
      return MEM_READ_CPU;
    end else if (q.read_ppu) begin
      return MEM_READ_PPU;
    end
    return MEM_REFRESH;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("ERROR %s: expected %0h, actual %0h", name, expected, actual));
    end
  endtask

  task automatic host_write(input logic [7:0] a, input logic [7:0] d);
    @(posedge clk);
    i_host_wr <= '{addr: a, data: d, valid: 1'b1};
    @(posedge clk);
    i_host_wr.valid <= 1'b0;
  endtask

  // random back-pressure from the memory controller
  always @(posedge clk) begin
    ready_state = xorshift(ready_state);
    i_mem_ready <= ready_state[3];
  end

  // every transferred command must match the oldest expected one
  always @(posedge clk) begin : cmd_monitor
    mem_cmd_t want;
    if (sys_resetn && o_mem_valid && i_mem_ready) begin
      if (exp_q.size() == 0) begin
        abort_run("a memory command was transferred when none was expected");
      end else begin
        want = exp_q.pop_front();
        check_value("memory command", want, o_mem_cmd);
        n_xfer++;
      end
    end
  end

  // a bound assertion failure ends the run at once
  always @(nes_bridge_top_i.nes_bridge_properties_i.n_fail) begin
    if (nes_bridge_top_i.nes_bridge_properties_i.n_fail != 0) begin
      abort_run("a bound assertion failed during the run");
    end
  end

  task automatic check_reset();
    int lows;
    lows = 0;
    // first edge that sees sys_resetn high starts the countdown
    @(posedge clk);
    @(posedge clk);
    while (!o_core_resetn) begin
      lows++;
      @(posedge clk);
    end
    check_value("power-on reset length", RESET_CYCLES, lows);
    i_reset_btn <= 1'b1;
    @(posedge clk);
    check_value("reset button delay", 1, o_core_resetn);
    @(posedge clk);
    check_value("reset button", 0, o_core_resetn);
    i_reset_btn <= 1'b0;
    repeat (2) @(posedge clk);
    check_value("reset button release", 1, o_core_resetn);
    // Select+Down forced by the host on player one
    host_write(REG_BTN_P1, 8'h24);
    host_p1 = 8'h24;
    @(posedge clk);
    check_value("combo delay", 1, o_core_resetn);
    @(posedge clk);
    check_value("select+down reset", 0, o_core_resetn);
    host_write(REG_BTN_P1, 8'h00);
    host_p1 = 8'h00;
    repeat (2) @(posedge clk);
    check_value("combo release", 1, o_core_resetn);
  endtask

  task automatic check_host_regs();
    logic [31:0] r;
    logic [7:0]  a;
    logic        exp_reset;
    exp_reset = 1'b0;
    for (int i = 0; i < N_HOST; i++) begin
      r = rand32();
      if (r[0]) begin
        host_write(REG_LOADER_CONF, r[15:8]);
        exp_reset = r[8];
      end else begin
        a = r[23:16];
        // keep away from the decoded addresses
        if (a == REG_LOADER_CONF || a == REG_BTN_P1 || a == REG_BTN_P2) begin
          a = a ^ 8'h80;
        end
        host_write(a, r[15:8]);
      end
      @(posedge clk);
      check_value("loader reset", exp_reset, o_loader_reset);
      check_value("core reset after host write", 1, o_core_resetn);
    end
    host_write(REG_LOADER_CONF, 8'h00);
  endtask

  task automatic load_rom();
    logic [31:0] r;
    logic [31:0] d;
    loader_wr_t  w;
    mem_cmd_t    e;
    for (int i = 0; i < N_LOAD; i++) begin
      r = rand32();
      d = rand32();
      w.addr  = r[0] ? TBL_ADDR[r[3:1]] : r[31:10];
      w.data  = d[7:0];
      w.valid = 1'b1;
      if (d[9:8] != 2'd0) begin
        i_loader_wr.valid <= 1'b0;
        repeat (d[9:8]) @(posedge clk);
      end
      i_loader_wr <= w;
      do begin
        @(posedge clk);
      end while (!o_loader_ready);
      e.op   = MEM_WRITE;
      e.addr = w.addr;
      e.data = patch_byte(w.addr, w.data);
      exp_q.push_back(e);
    end
    i_loader_wr.valid <= 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    // slot drained, loader port open again
    @(posedge clk);
    check_value("slot free after loading", 2'b01, {o_mem_valid, o_loader_ready});
  endtask

  task automatic drive_request();
    logic [31:0]  r;
    nes_mem_req_t q;
    mem_cmd_t     e;
    r = rand32();
    q.read_cpu = r[0];
    q.read_ppu = r[1];
    q.write    = r[2] & r[3];
    q.addr     = r[31:10];
    q.data     = r[9:2];
    e.op   = expected_op(q);
    e.addr = q.addr;
    e.data = q.data;
    i_nes_req <= q;
    exp_q.push_back(e);
  endtask

  // a new request after each NES step, used by the next memory slot
  task automatic run_periods();
    int pulses;
    int base;
    base   = n_xfer;
    pulses = 0;
    drive_request();
    i_loader_done <= 1'b1;
    while (pulses < N_RUN) begin
      @(posedge clk);
      if (o_run_nes) begin
        pulses++;
        // the slot of this period may still wait for ready
        check_value("commands per NES step", 1,
                    (n_xfer - base == pulses) || (n_xfer - base == pulses - 1));
        if (pulses < N_RUN) begin
          drive_request();
        end else begin
          i_loader_done <= 1'b0;
        end
      end
    end
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    @(posedge clk);
    check_value("idle after NES run", 3'b001, {o_mem_valid, o_run_nes, o_loader_ready});
  endtask

  task automatic pad_step(input logic s, input logic [1:0] k);
    logic [7:0] merged [2];
    logic       fall;
    @(posedge clk);
    merged[0] = i_pad_btn_p1 | host_p1;
    merged[1] = i_pad_btn_p2 | host_p2;
    for (int p = 0; p < 2; p++) begin
      check_value($sformatf("joypad p%0d", p + 1), pad_model[p][0], o_pad_data[p]);
      fall = pad_clk_prev[p] & ~i_pad_ctrl.clk[p];
      if (fall) begin
        pad_model[p] = {1'b0, pad_model[p][7:1]};
      end else if (i_pad_ctrl.strobe) begin
        pad_model[p] = merged[p];
      end
      pad_clk_prev[p] = i_pad_ctrl.clk[p];
    end
    i_pad_ctrl <= '{strobe: s, clk: k};
  endtask

  task automatic check_joypads();
    logic [31:0] r;
    r = rand32();
    // select stays clear on player one so the core is not reset
    host_write(REG_BTN_P1, r[7:0] & 8'hFB);
    host_p1 = r[7:0] & 8'hFB;
    host_write(REG_BTN_P2, r[15:8]);
    host_p2 = r[15:8];
    i_pad_btn_p1 <= r[23:16] & 8'hFB;
    i_pad_btn_p2 <= r[31:24];
    for (int i = 0; i < N_PAD; i++) begin
      r = rand32();
      pad_step(r[2:0] == 3'd0, r[4:3]);
    end
    // load once, then clock out all eight bits
    i_pad_btn_p1 <= 8'hFB;
    i_pad_btn_p2 <= 8'hFF;
    pad_step(1'b0, 2'b00);
    pad_step(1'b1, 2'b00);
    pad_step(1'b0, 2'b00);
    for (int i = 0; i < 8; i++) begin
      pad_step(1'b0, 2'b11);
      pad_step(1'b0, 2'b00);
    end
    pad_step(1'b0, 2'b00);
    pad_step(1'b0, 2'b00);
    check_value("joypad after eight shifts", 0, o_pad_data);
  endtask

  initial begin
    repeat (LIMIT) @(posedge clk);
    abort_run("timeout: the tests did not finish before the watchdog expired");
  end

  initial begin
    sys_resetn    = 1'b0;
    i_reset_btn   = 1'b0;
    i_host_wr     = '0;
    i_loader_wr   = '0;
    i_loader_done = 1'b0;
    i_nes_req     = '0;
    i_mem_ready   = 1'b0;
    i_pad_ctrl    = '0;
    i_pad_btn_p1  = '0;
    i_pad_btn_p2  = '0;
    repeat (2) @(posedge clk);
    check_value("state after reset", 0,
                {o_mem_valid, o_run_nes, o_loader_ready, o_core_resetn, o_pad_data});
    sys_resetn <= 1'b1;
    check_reset();
    check_host_regs();
    load_rom();
    run_periods();
    check_joypads();
    @(posedge clk);
    if (nes_bridge_top_i.nes_bridge_properties_i.n_fail != 0) begin
      abort_run("a bound assertion failed during the run");
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

// File: build.f
hdl/nes_bridge_pkg.sv
hdl/reset_sequencer.sv
hdl/host_regs.sv
hdl/rom_patch.sv
hdl/phase_sequencer.sv
hdl/mem_arbiter.sv
hdl/joypad_port.sv
hdl/nes_bridge_top.sv
bench/nes_bridge_properties.sv
bench/tb_nes_bridge.sv
